/* rv_ex.f */
rv_isa_pkg.sv
rv_core_pkg.sv
ex_alu.sv
ex_decode.sv
ex.sv
ex_out_reg.sv
ex_top.sv
ex_checker.sv
tb_clock_gen.sv
tb_ex_top.sv

/* tb_ex_top.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_ex_top;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    // reset, 39 single issues, a stalled stream of 16, fence.i, six test ends.
    localparam int stim_cycles = 5 + 39 + 4 * 16 + 8 + 4 * 6;
    localparam int max_cycles  = 2 * stim_cycles + 100;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    logic [inst_w-1:0] inst;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   rs1_data;
    logic [xlen-1:0]   rs2_data;
    logic [xlen-1:0]   csr_rdata;
    logic              fence_i_req;
    logic              icache_flush;
    logic              out_valid;
    logic              out_ready;
    logic [xlen-1:0]   out_result;
    logic [xlen-1:0]   out_dnpc;
    logic              out_jump;
    logic              stream_done;
    int                seed = 54169;
    int                cycle_count = 0;
    int                tests = 0;
    int                failed_tests = 0;
    int                fails_seen = 0;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    ex_top UUT (.*);

    bind ex_top ex_checker u_checker (.*);

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_reg};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input opcode_e opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input branch_f3_e f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, op_jal};
    endfunction

    // starts on a rising edge and returns on the transfer edge.
    task automatic issue(input logic [31:0] word, input bit same_regs);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = same_regs ? a : $random(seed);
        in_valid  <= 1'b1;
        inst      <= word;
        pc        <= $random(seed) & 32'hffff_fffc;
        rs1_data  <= a;
        rs2_data  <= b;
        csr_rdata <= $random(seed);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic end_test(input string name);
        int fails;
        repeat (2) @(posedge clk);
        @(negedge clk);
        fails      = UUT.u_checker.fail_count - fails_seen;
        fails_seen = UUT.u_checker.fail_count;
        tests++;
        if (fails != 0) failed_tests++;
        $display("%-14s %s, %0d assertion failures", name, (fails == 0) ? "ok" : "fail", fails);
        @(posedge clk);
    endtask

    initial begin
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        branch_f3_e  br;
        int          bp_seed;
        in_valid    = 1'b0;
        inst        = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        csr_rdata   = '0;
        fence_i_req = 1'b0;
        out_ready   = 1'b1;
        stream_done = 1'b0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);

        // ==================================================================
        // alu ops in register and immediate form.
        // ==================================================================
        for (int f3 = 0; f3 < 8; f3++) begin
            issue(r_word(7'h00, 3'(f3)), 1'b0);
            if (f3 == 0 || f3 == 5) issue(r_word(7'h20, 3'(f3)), 1'b0);
            imm = 12'($random(seed));
            if (f3 == 1 || f3 == 5) imm[11:5] = 7'h00;     // shift amount only.
            issue(i_word(imm, 3'(f3), op_imm), 1'b0);
            if (f3 == 5) issue(i_word({7'h20, imm[4:0]}, 3'd5, op_imm), 1'b0);  // srai.
        end
        end_test("alu");

        br = br.first();
        repeat (br.num()) begin
            boff = 13'($random(seed));
            boff[0] = 1'b0;
            issue(branch_word(boff, br), 1'b0);
            issue(branch_word(boff, br), 1'b1);   // equal operands.
            br = br.next();
        end
        end_test("branch");

        repeat (3) begin
            joff = 21'($random(seed));
            joff[0] = 1'b0;
            issue(jal_word(joff), 1'b0);
            issue(i_word(12'($random(seed)), 3'd0, op_jalr), 1'b0);
        end
        end_test("jump");

        issue(inst_ecall, 1'b0);
        issue(inst_mret, 1'b0);
        end_test("ecall/mret");

        fence_i_req <= 1'b1;
        repeat (4) @(posedge clk);
        fence_i_req <= 1'b0;
        repeat (2) @(posedge clk);
        fence_i_req <= 1'b1;
        repeat (2) @(posedge clk);
        fence_i_req <= 1'b0;
        end_test("fence.i");

        // ==================================================================
        // random out_ready under a back-to-back stream.
        // ==================================================================
        bp_seed = seed;
        fork
            begin
                repeat (16) issue(r_word(7'h00, 3'($random(seed))), 1'b0);
                stream_done <= 1'b1;
            end
            begin
                while (!stream_done) begin
                    out_ready <= 1'($random(bp_seed));
                    @(posedge clk);
                end
                out_ready <= 1'b1;
            end
        join
        end_test("back-pressure");

        $display("%0d tests, %0d failed, %0d assertion failures", tests, failed_tests,
                 fails_seen);
        if (failed_tests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d cycles", max_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 20;   // 40 ns clock.
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* ex_checker.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          in_ready,
    input logic [rv_isa_pkg::inst_w-1:0] inst,
    input logic [rv_core_pkg::xlen-1:0]  pc,
    input logic [rv_core_pkg::xlen-1:0]  rs1_data,
    input logic [rv_core_pkg::xlen-1:0]  rs2_data,
    input logic [rv_core_pkg::xlen-1:0]  csr_rdata,
    input logic                          fence_i_req,
    input logic                          icache_flush,
    input logic                          out_valid,
    input logic                          out_ready,
    input logic [rv_core_pkg::xlen-1:0]  out_result,
    input logic [rv_core_pkg::xlen-1:0]  out_dnpc,
    input logic                          out_jump
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e         opc;
    logic            xfer;
    logic            taken;
    logic            exp_jump;
    logic            check_res;
    logic            check_res_q;
    logic            jump_q;
    logic            req_q;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] exp_res;
    logic [xlen-1:0] exp_dnpc;
    logic [xlen-1:0] res_q;
    logic [xlen-1:0] dnpc_q;
    int unsigned     accepted;
    int unsigned     delivered;
    int              fail_count = 0;

    assign opc   = opcode_e'(inst[6:0]);
    assign xfer  = in_valid && in_ready;
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign op_b  = (opc == op_imm) ? imm_i : rs2_data;

    // ======================================================================
    // expected stage result from the isa rules.
    // ======================================================================
    always_comb begin
        case (inst[14:12])
            3'd0: exp_res = (opc == op_reg && inst[30]) ? rs1_data - op_b : rs1_data + op_b;
            3'd1: exp_res = rs1_data << op_b[4:0];
            3'd2: exp_res = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            3'd3: exp_res = {{(xlen-1){1'b0}}, rs1_data < op_b};
            3'd4: exp_res = rs1_data ^ op_b;
            3'd5: begin
                if (inst[30]) exp_res = $signed(rs1_data) >>> op_b[4:0];
                else exp_res = rs1_data >> op_b[4:0];
            end
            3'd6: exp_res = rs1_data | op_b;
            default: exp_res = rs1_data & op_b;
        endcase
        case (branch_f3_e'(inst[14:12]))
            beq:     taken = (rs1_data == rs2_data);
            bne:     taken = (rs1_data != rs2_data);
            blt:     taken = $signed(rs1_data) < $signed(rs2_data);
            bge:     taken = $signed(rs1_data) >= $signed(rs2_data);
            bltu:    taken = rs1_data < rs2_data;
            bgeu:    taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
        check_res = (opc == op_reg) || (opc == op_imm);
        exp_jump  = 1'b0;
        exp_dnpc  = pc + pc_step;
        case (opc)
            op_jal, op_jalr: begin
                exp_res   = pc + pc_step;   // link address.
                exp_dnpc  = (opc == op_jal) ? pc + imm_j : rs1_data + imm_i;
                exp_jump  = 1'b1;
                check_res = 1'b1;
            end
            op_branch: begin
                exp_jump = taken;
                if (taken) exp_dnpc = pc + imm_b;
            end
            op_system: if (inst == inst_ecall || inst == inst_mret) exp_dnpc = csr_rdata;
            default: exp_jump = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            res_q       <= exp_res;
            dnpc_q      <= exp_dnpc;
            jump_q      <= exp_jump;
            check_res_q <= check_res;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accepted  <= 0;
            delivered <= 0;
            req_q     <= 1'b0;
        end else begin
            if (xfer) accepted <= accepted + 1;
            if (out_valid && out_ready) delivered <= delivered + 1;
            req_q <= fence_i_req;
        end
    end

    // ======================================================================
    // assertions.
    // ======================================================================
    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |=> !check_res_q || out_result == res_q)
        else begin
            fail_count++;
            $error("Error at %0t: out_result expected %h, got %h",
                   $time, $sampled(res_q), $sampled(out_result));
        end

    a_dnpc: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |=> out_dnpc == dnpc_q)
        else begin
            fail_count++;
            $error("Error at %0t: out_dnpc expected %h, got %h",
                   $time, $sampled(dnpc_q), $sampled(out_dnpc));
        end

    a_jump: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |=> out_jump == jump_q)
        else begin
            fail_count++;
            $error("Error at %0t: out_jump expected %b, got %b",
                   $time, $sampled(jump_q), $sampled(out_jump));
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        icache_flush == (fence_i_req && !req_q))
        else begin
            fail_count++;
            $error("Error at %0t: icache_flush expected %b, got %b",
                   $time, $sampled(fence_i_req && !req_q), $sampled(icache_flush));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_result) && $stable(out_dnpc) && $stable(out_jump))
        else begin
            fail_count++;
            $error("output changed at %0t while the consumer was stalling it", $time);
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && out_valid && !out_ready |-> !in_ready)
        else begin
            fail_count++;
            $error("Error at %0t: in_ready expected 0, got 1", $time);
        end

    // one in flight at most, none dropped or repeated.
    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        (accepted - delivered) == (out_valid ? 1 : 0))
        else begin
            fail_count++;
            $error("at %0t %0d accepted and %0d delivered do not match the output register",
                   $time, $sampled(accepted), $sampled(delivered));
        end

    a_reset: assert property (@(posedge clk) !rst_n |=> !out_valid && !out_jump)
        else begin
            fail_count++;
            $error("out_valid or out_jump high at %0t after a reset cycle", $time);
        end

endmodule

`default_nettype wire

/* ex_top.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [rv_isa_pkg::inst_w-1:0] inst,
    input  logic [rv_core_pkg::xlen-1:0]  pc,
    input  logic [rv_core_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]  rs2_data,
    input  logic [rv_core_pkg::xlen-1:0]  csr_rdata,
    input  logic                          fence_i_req,
    output logic                          icache_flush,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [rv_core_pkg::xlen-1:0]  out_result,
    output logic [rv_core_pkg::xlen-1:0]  out_dnpc,
    output logic                          out_jump
);
    import rv_core_pkg::*;

    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] pc_adder_src2;
    alu_op_e         alu_ctrl;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] dnpc;
    logic            this_valid;
    logic            next_ready;
    logic            ex_jump;

    ex_decode u_decode (
        .inst          (inst),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .alu_ctrl      (alu_ctrl),
        .imm_i         (imm_i),
        .pc_adder_src2 (pc_adder_src2)
    );

    ex u_ex (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst          (inst),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .alu_ctrl      (alu_ctrl),
        .imm_i         (imm_i),
        .pc_adder_src2 (pc_adder_src2),
        .csr_rdata     (csr_rdata),
        .fence_i_req   (fence_i_req),
        .icache_flush  (icache_flush),
        .alu_result    (alu_result),
        .dnpc          (dnpc),
        .prev_valid    (in_valid),
        .this_ready    (in_ready),
        .next_ready    (next_ready),
        .this_valid    (this_valid),
        .ex_jump       (ex_jump)
    );

    ex_out_reg u_out_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .this_valid (this_valid),
        .ex_jump    (ex_jump),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .out_ready  (out_ready),
        .next_ready (next_ready),
        .out_valid  (out_valid),
        .out_jump   (out_jump),
        .out_result (out_result),
        .out_dnpc   (out_dnpc)
    );

endmodule

`default_nettype wire

/* ex_out_reg.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_out_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         this_valid,
    input  logic                         ex_jump,
    input  logic [rv_core_pkg::xlen-1:0] alu_result,
    input  logic [rv_core_pkg::xlen-1:0] dnpc,
    input  logic                         out_ready,
    output logic                         next_ready,
    output logic                         out_valid,
    output logic                         out_jump,
    output logic [rv_core_pkg::xlen-1:0] out_result,
    output logic [rv_core_pkg::xlen-1:0] out_dnpc
);
    logic load;

    // empty or draining this cycle.
    assign next_ready = !out_valid || out_ready;
    assign load       = this_valid && next_ready;

    // ======================================================================
    // control.
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_jump  <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_jump  <= ex_jump;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // read, nothing behind it.
            out_jump  <= 1'b0;
        end
    end

    // payload.
    always_ff @(posedge clk) begin
        if (load) begin
            out_result <= alu_result;
            out_dnpc   <= dnpc;
        end
    end

endmodule

`default_nettype wire

/* ex.sv */
`default_nettype none
`timescale 1ns/1ns

module ex (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_isa_pkg::inst_w-1:0] inst,
    input  logic [rv_core_pkg::xlen-1:0]  alu_src1,
    input  logic [rv_core_pkg::xlen-1:0]  alu_src2,
    input  rv_core_pkg::alu_op_e          alu_ctrl,
    input  logic [rv_core_pkg::xlen-1:0]  imm_i,
    input  logic [rv_core_pkg::xlen-1:0]  pc_adder_src2,
    input  logic [rv_core_pkg::xlen-1:0]  csr_rdata,
    input  logic                          fence_i_req,
    output logic                          icache_flush,
    output logic [rv_core_pkg::xlen-1:0]  alu_result,
    output logic [rv_core_pkg::xlen-1:0]  dnpc,
    input  logic                          prev_valid,
    output logic                          this_ready,
    input  logic                          next_ready,
    output logic                          this_valid,
    output logic                          ex_jump
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e         opcode;
    branch_f3_e      funct3;
    logic            is_trap_ret;
    logic            fence_i_req_q;
    logic            zero_flag;
    logic            less_flag;
    logic            op_eq;
    logic            op_lt_s;
    logic            op_lt_u;
    logic            jump_flag;
    logic [xlen-1:0] pc_offset;

    assign opcode      = opcode_e'(inst[6:0]);
    assign funct3      = branch_f3_e'(inst[14:12]);
    assign is_trap_ret = (inst == inst_ecall) || (inst == inst_mret);

    // ======================================================================
    // fence.i flush, one cycle per request rise.
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fence_i_req_q <= 1'b0;
        end else begin
            fence_i_req_q <= fence_i_req;
        end
    end

    assign icache_flush = fence_i_req & ~fence_i_req_q;

    // single-cycle stage, always done.
    assign this_ready = !prev_valid || next_ready;
    assign this_valid = prev_valid;

    ex_alu u_alu (
        .a         (alu_src1),
        .b         (alu_src2),
        .ctrl      (alu_ctrl),
        .result    (alu_result),
        .zero_flag (zero_flag),
        .less_flag (less_flag)
    );

    // ======================================================================
    // next pc.
    // ======================================================================
    always_comb begin
        pc_offset = pc_step;
        case (opcode)
            op_jal, op_jalr: pc_offset = imm_i;
            op_branch: begin
                case (funct3)
                    beq:        pc_offset = zero_flag ? imm_i : pc_step;
                    bne:        pc_offset = zero_flag ? pc_step : imm_i;
                    blt, bltu:  pc_offset = less_flag ? imm_i : pc_step;   // flag type from alu_ctrl.
                    bge, bgeu:  pc_offset = less_flag ? pc_step : imm_i;
                    default:    pc_offset = pc_step;
                endcase
            end
            default: pc_offset = pc_step;
        endcase
    end

    assign dnpc = is_trap_ret ? csr_rdata : (pc_adder_src2 + pc_offset);

    // ======================================================================
    // jump decision.
    // ======================================================================
    assign op_eq   = (alu_src1 == alu_src2);
    assign op_lt_s = $signed(alu_src1) < $signed(alu_src2);
    assign op_lt_u = alu_src1 < alu_src2;

    always_comb begin
        jump_flag = 1'b0;
        case (opcode)
            op_jal, op_jalr: jump_flag = 1'b1;
            op_branch: begin
                case (funct3)
                    beq:     jump_flag = op_eq;
                    bne:     jump_flag = ~op_eq;
                    blt:     jump_flag = op_lt_s;
                    bge:     jump_flag = ~op_lt_s;
                    bltu:    jump_flag = op_lt_u;
                    bgeu:    jump_flag = ~op_lt_u;
                    default: jump_flag = 1'b0;
                endcase
            end
            default: jump_flag = 1'b0;
        endcase
    end

    assign ex_jump = jump_flag & this_valid & next_ready;  // only on transfer.

endmodule

`default_nettype wire

/* ex_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_decode (
    input  logic [rv_isa_pkg::inst_w-1:0] inst,
    input  logic [rv_core_pkg::xlen-1:0]  pc,
    input  logic [rv_core_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]  rs2_data,
    output logic [rv_core_pkg::xlen-1:0]  alu_src1,
    output logic [rv_core_pkg::xlen-1:0]  alu_src2,
    output rv_core_pkg::alu_op_e          alu_ctrl,
    output logic [rv_core_pkg::xlen-1:0]  imm_i,
    output logic [rv_core_pkg::xlen-1:0]  pc_adder_src2
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e         opcode;
    alu_f3_e         funct3;
    logic            alt;           // funct7[5].
    logic [xlen-1:0] imm_itype;
    logic [xlen-1:0] imm_stype;
    logic [xlen-1:0] imm_btype;
    logic [xlen-1:0] imm_utype;
    logic [xlen-1:0] imm_jtype;

    // sub only exists in register form.
    function automatic alu_op_e int_op(input alu_f3_e f3, input logic f7b5, input logic is_reg);
        case (f3)
            f3_add_sub: return (is_reg && f7b5) ? alu_sub : alu_add;
            f3_sll:     return alu_sll;
            f3_slt:     return alu_slt;
            f3_sltu:    return alu_sltu;
            f3_xor:     return alu_xor;
            f3_srl_sra: return f7b5 ? alu_sra : alu_srl;
            f3_or:      return alu_or;
            default:    return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = alu_f3_e'(inst[14:12]);
    assign alt    = inst[30];

    assign imm_itype = {{20{inst[31]}}, inst[31:20]};
    assign imm_stype = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_btype = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_utype = {inst[31:12], 12'b0};
    assign imm_jtype = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm_i         = imm_itype;
        alu_src1      = rs1_data;
        alu_src2      = rs2_data;
        pc_adder_src2 = pc;
        alu_ctrl      = alu_add;
        case (opcode)
            op_lui: begin
                imm_i    = imm_utype;
                alu_src2 = imm_utype;
                alu_ctrl = alu_pass_b;
            end
            op_auipc: begin
                imm_i    = imm_utype;
                alu_src1 = pc;
                alu_src2 = imm_utype;
            end
            op_jal, op_jalr: begin
                if (opcode == op_jal) imm_i = imm_jtype;
                alu_src1 = pc;      // link address.
                alu_src2 = pc_step;
                if (opcode == op_jalr) pc_adder_src2 = rs1_data;
            end
            op_branch: begin
                imm_i    = imm_btype;
                alu_ctrl = inst[13] ? alu_sltu : alu_sub;   // bltu, bgeu.
            end
            op_load: alu_src2 = imm_itype;
            op_store: begin
                imm_i    = imm_stype;
                alu_src2 = imm_stype;
            end
            op_imm: begin
                alu_src2 = imm_itype;
                alu_ctrl = int_op(funct3, alt, 1'b0);
            end
            op_reg: alu_ctrl = int_op(funct3, alt, 1'b1);
            default: imm_i = imm_itype;
        endcase
    end

endmodule

`default_nettype wire

/* ex_alu.sv */
`default_nettype none
`timescale 1ns/1ns

module ex_alu (
    input  logic [rv_core_pkg::xlen-1:0] a,
    input  logic [rv_core_pkg::xlen-1:0] b,
    input  rv_core_pkg::alu_op_e         ctrl,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic                         zero_flag,
    output logic                         less_flag
);
    import rv_core_pkg::*;

    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign shamt       = b[4:0];

    // ======================================================================
    // result mux.
    // ======================================================================
    always_comb begin
        case (ctrl)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    assign zero_flag = (result == '0);

    // sltu selects unsigned, everything else signed.
    assign less_flag = (ctrl == alu_sltu) ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    // fall-through step.
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // ======================================================================
    // alu operations.
    // ======================================================================
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // lui.
    } alu_op_e;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int inst_w = 32;

    // ======================================================================
    // major opcodes, inst[6:0].
    // ======================================================================
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    // ======================================================================
    // funct3 fields, inst[14:12].
    // ======================================================================
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_f3_e;

    // integer ops, shared by op_imm and op_reg.
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } alu_f3_e;

    // fixed words, matched as a whole.
    localparam logic [inst_w-1:0] inst_ecall = 32'h0000_0073;
    localparam logic [inst_w-1:0] inst_mret  = 32'h3020_0073;

endpackage

`default_nettype wire
